//--- Bender.yml
package:
  name: spi_reg

sources:
  - source/regs_pkg.sv
  - source/spi_frame_rx.sv
  - source/host_port.sv
  - source/reg_arbiter.sv
  - source/reg_bank.sv
  - source/spi_reg_top.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/spi_reg_tb.sv

//--- dv/spi_reg_tb.sv
/*
  Testbench for the SPI register block.
  Runs a table of SPI frames and host port accesses against the DUT,
  with a register model that supplies the expected read data and port
  values. Some host accesses are launched in the middle of an SPI frame
  so that both peers contend for the bank.
*/
`timescale 1ns/1ps

module spi_reg_tb
  import regs_pkg::*;
;

  localparam int  HALF      = 10;   // spi clock half-period in cs cycles.
  localparam int  SETTLE    = 24;   // sync, arbitration and one host handshake.
  localparam int  HOST_WAIT = 64;
  localparam int  HOST_LAG  = 2 * HALF * CMD_BITS - HALF + 4;  // near the spi read request.
  localparam int  MAX_ENT   = 64;
  localparam bit  PORT_SPI  = 1'b0;
  localparam bit  PORT_HOST = 1'b1;

  logic              cs;
  logic              rst;
  logic              sclk;
  logic              ss_n;
  logic              mosi;
  logic              miso;
  logic              host_valid;
  reg_op_t           host_op;
  logic [ADDR_W-1:0] host_idx;
  logic [DATA_W-1:0] host_wdata;
  logic              host_rd;
  logic              host_busy;
  logic              host_done;
  logic [DATA_W-1:0] host_rdata;
  logic [DATA_W-1:0] reg_led;
  logic [DATA_W-1:0] reg_spi_mux;
  logic [DATA_W-1:0] reg_4094;
  logic [DATA_W-1:0] reg_mode;
  logic [DATA_W-1:0] reg_direct;

  // stimulus table, one column per field.
  bit                t_port [MAX_ENT];
  logic              t_rd   [MAX_ENT];
  reg_op_t           t_op   [MAX_ENT];
  logic [ADDR_W-1:0] t_idx  [MAX_ENT];
  logic [DATA_W-1:0] t_data [MAX_ENT];
  int                t_bits [MAX_ENT];
  bit                t_par  [MAX_ENT];  // host entry runs inside the next spi frame.
  logic [DATA_W-1:0] t_exp  [MAX_ENT];
  int                n_entries = 0;

  logic [DATA_W-1:0] rm [0:31];  // register values as seen on the ports.
  logic [ADDR_W-1:0] idx_list [5];
  int unsigned       seed_val;
  int                mismatches = 0;
  int                failures   = 0;
  int                cycles     = 0;
  int                limit      = 0;

  tb_clock clk0 (
    .cs  (cs),
    .rst (rst)
  );

  spi_reg_top dut0 (
    .cs          (cs),
    .rst         (rst),
    .sclk        (sclk),
    .ss_n        (ss_n),
    .mosi        (mosi),
    .miso        (miso),
    .host_valid  (host_valid),
    .host_op     (host_op),
    .host_idx    (host_idx),
    .host_wdata  (host_wdata),
    .host_rd     (host_rd),
    .host_busy   (host_busy),
    .host_done   (host_done),
    .host_rdata  (host_rdata),
    .reg_led     (reg_led),
    .reg_spi_mux (reg_spi_mux),
    .reg_4094    (reg_4094),
    .reg_mode    (reg_mode),
    .reg_direct  (reg_direct)
  );

  // inputs move 1 ns after the rising edge.
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge cs);
    #1;
  endtask

  function automatic logic known_index(input logic [ADDR_W-1:0] idx);
    return (idx == IDX_LED) || (idx == IDX_SPI_MUX) || (idx == IDX_4094) ||
           (idx == IDX_MODE) || (idx == IDX_DIRECT);
  endfunction

  // update rule of the register map.
  function automatic logic [DATA_W-1:0] apply_rule(
    input logic [DATA_W-1:0] cur,
    input reg_op_t           op,
    input logic [DATA_W-1:0] val
  );
    case (op)
      OP_SET:    return cur | val;
      OP_CLEAR:  return cur & ~val;
      OP_TOGGLE: return cur ^ val;
      default:   return val;  // plain write.
    endcase
  endfunction

  task automatic add_entry(input bit port, input logic rd, input reg_op_t op,
                           input logic [ADDR_W-1:0] idx, input logic [DATA_W-1:0] data,
                           input int bits, input bit par);
    t_port[n_entries] = port;
    t_rd[n_entries]   = rd;
    t_op[n_entries]   = op;
    t_idx[n_entries]  = idx;
    t_data[n_entries] = data;
    t_bits[n_entries] = bits;
    t_par[n_entries]  = par;
    n_entries++;
  endtask

  task automatic build_table();
    reg_op_t op;
    for (int j = 0; j < 5; j++)
      add_entry(PORT_SPI, 1'b1, OP_WRITE, idx_list[j], '0, FRAME_BITS, 1'b0);  // reset values.
    for (int j = 0; j < 5; j++)
    begin
      add_entry(PORT_SPI, 1'b0, OP_WRITE, idx_list[j], $urandom, FRAME_BITS, 1'b0);
      add_entry(PORT_SPI, 1'b1, OP_WRITE, idx_list[j], '0, FRAME_BITS, 1'b0);
      add_entry(PORT_HOST, 1'b1, OP_WRITE, idx_list[j], '0, FRAME_BITS, 1'b0);
    end
    // set, clear, toggle from each peer, read back through the other.
    for (int j = 0; j < 6; j++)
    begin
      op = reg_op_t'(1 + j % 3);
      add_entry(j >= 3, 1'b0, op, idx_list[j % 5], $urandom, FRAME_BITS, 1'b0);
      add_entry(j < 3, 1'b1, OP_WRITE, idx_list[j % 5], '0, FRAME_BITS, 1'b0);
    end
    add_entry(PORT_SPI, 1'b1, OP_WRITE, 5'd3, '0, FRAME_BITS, 1'b0);  // unmapped.
    add_entry(PORT_HOST, 1'b1, OP_WRITE, 5'd31, '0, FRAME_BITS, 1'b0);
    add_entry(PORT_SPI, 1'b0, OP_WRITE, 5'd5, $urandom, FRAME_BITS, 1'b0);
    add_entry(PORT_HOST, 1'b0, OP_SET, 5'd20, $urandom, FRAME_BITS, 1'b0);
    add_entry(PORT_SPI, 1'b0, OP_WRITE, IDX_LED, $urandom, 40, 1'b0);  // short frame.
    add_entry(PORT_SPI, 1'b0, OP_WRITE, IDX_MODE, $urandom, 56, 1'b0);  // long frame.
    add_entry(PORT_SPI, 1'b0, OP_SET, IDX_4094, $urandom, 40, 1'b0);
    // host access overlapping an spi frame, distinct registers.
    add_entry(PORT_HOST, 1'b1, OP_WRITE, IDX_LED, '0, FRAME_BITS, 1'b1);
    add_entry(PORT_SPI, 1'b1, OP_WRITE, IDX_4094, '0, FRAME_BITS, 1'b0);
    add_entry(PORT_HOST, 1'b0, OP_SET, IDX_MODE, $urandom, FRAME_BITS, 1'b1);
    add_entry(PORT_SPI, 1'b0, OP_WRITE, IDX_DIRECT, $urandom, FRAME_BITS, 1'b0);
    add_entry(PORT_HOST, 1'b0, OP_TOGGLE, IDX_SPI_MUX, $urandom, FRAME_BITS, 1'b1);
    add_entry(PORT_SPI, 1'b0, OP_CLEAR, IDX_LED, $urandom, FRAME_BITS, 1'b0);
    add_entry(PORT_SPI, 1'b1, OP_WRITE, IDX_MODE, '0, FRAME_BITS, 1'b0);
    add_entry(PORT_HOST, 1'b1, OP_WRITE, IDX_DIRECT, '0, FRAME_BITS, 1'b0);
    add_entry(PORT_SPI, 1'b1, OP_WRITE, IDX_SPI_MUX, '0, FRAME_BITS, 1'b0);
  endtask

  // walk the table through the model to get the expected column.
  task automatic fill_expected();
    logic [DATA_W-1:0] bm [0:31];
    for (int j = 0; j < 32; j++)
      bm[j] = '0;
    bm[IDX_LED] = RST_LED;
    for (int k = 0; k < n_entries; k++)
    begin
      t_exp[k] = '0;
      if (t_rd[k])
        t_exp[k] = known_index(t_idx[k]) ? bm[t_idx[k]] : FILL_PATTERN;
      else if (t_bits[k] == FRAME_BITS && known_index(t_idx[k]))
      begin
        bm[t_idx[k]] = apply_rule(bm[t_idx[k]], t_op[k], t_data[k]);
        t_exp[k]     = bm[t_idx[k]];
      end
    end
  endtask

  task automatic compare_value(input string name, input int entry,
                               input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
    assert (got === exp)
    else
    begin
      $display("MISMATCH %s expected %h got %h (entry %0d)", name, exp, got, entry);
      mismatches++;
    end
  endtask

  task automatic verify_ports(input int entry);
    compare_value("reg_led", entry, reg_led, rm[IDX_LED]);
    compare_value("reg_spi_mux", entry, reg_spi_mux, rm[IDX_SPI_MUX]);
    compare_value("reg_4094", entry, reg_4094, rm[IDX_4094]);
    compare_value("reg_mode", entry, reg_mode, rm[IDX_MODE]);
    compare_value("reg_direct", entry, reg_direct, rm[IDX_DIRECT]);
  endtask

  // bit-banged frame, mosi set on the falling sclk, miso read before the rise.
  task automatic spi_frame(input logic rd, input reg_op_t op, input logic [ADDR_W-1:0] idx,
                           input logic [DATA_W-1:0] data, input int nbits,
                           output logic [DATA_W-1:0] rdata);
    logic [63:0] frame;
    int          k;
    frame = {rd, op, idx, 8'h00, data, 16'hc3a5};  // cmd, pad, data, spare.
    rdata = '0;
    ss_n  = 1'b0;
    mosi  = frame[63];
    wait_cycles(HALF);
    for (k = 0; k < nbits; k++)
    begin
      if (k >= 2 * CMD_BITS && k < FRAME_BITS)
        rdata = {rdata[DATA_W-2:0], miso};
      sclk = 1'b1;
      wait_cycles(HALF);
      sclk = 1'b0;
      mosi = frame[62 - k];
      wait_cycles(HALF);
    end
    ss_n = 1'b1;
    mosi = 1'b0;
    wait_cycles(SETTLE);  // lets a closing write reach the bank.
  endtask

  task automatic host_access(input logic rd, input reg_op_t op, input logic [ADDR_W-1:0] idx,
                             input logic [DATA_W-1:0] data, input int entry,
                             output logic [DATA_W-1:0] rdata);
    int waited;
    host_rd    = rd;
    host_op    = op;
    host_idx   = idx;
    host_wdata = data;
    host_valid = 1'b1;
    wait_cycles(1);
    host_valid = 1'b0;  // one-cycle strobe.
    waited     = 0;
    while (!host_done && waited < HOST_WAIT)
    begin
      compare_value("host_busy", entry, host_busy, 1'b1);  // high until the done pulse.
      wait_cycles(1);
      waited++;
    end
    assert (host_done)
    else
    begin
      $display("host port gave no done pulse within %0d cycles", HOST_WAIT);
      failures++;
    end
    if (host_done)
      compare_value("host_busy", entry, host_busy, 1'b0);  // drops with done.
    rdata = host_rdata;
  endtask

  task automatic run_entry(input int k, output logic [DATA_W-1:0] got);
    if (t_port[k] == PORT_SPI)
      spi_frame(t_rd[k], t_op[k], t_idx[k], t_data[k], t_bits[k], got);
    else
      host_access(t_rd[k], t_op[k], t_idx[k], t_data[k], k, got);
  endtask

  task automatic close_entry(input int k, input logic [DATA_W-1:0] got);
    if (t_rd[k])
      compare_value(t_port[k] == PORT_SPI ? "miso" : "host_rdata", k, got, t_exp[k]);
    else if (t_bits[k] == FRAME_BITS && known_index(t_idx[k]))
      rm[t_idx[k]] = t_exp[k];  // write landed.
  endtask

  // run limit from the table length.
  always @(posedge cs)
  begin
    cycles++;
    if (limit > 0 && cycles >= limit)
    begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
      $display("Some tests failed");
      $finish;
    end
  end

  initial
  begin : main
    logic [DATA_W-1:0] got_a;
    logic [DATA_W-1:0] got_b;
    int                i;
    seed_val   = $urandom(81742);
    sclk       = 1'b0;
    ss_n       = 1'b1;  // deselected.
    mosi       = 1'b0;
    host_valid = 1'b0;
    host_op    = OP_WRITE;
    host_idx   = '0;
    host_wdata = '0;
    host_rd    = 1'b0;
    idx_list   = '{IDX_LED, IDX_SPI_MUX, IDX_4094, IDX_MODE, IDX_DIRECT};
    for (int j = 0; j < 32; j++)
      rm[j] = '0;
    rm[IDX_LED] = RST_LED;
    build_table();
    fill_expected();
    limit = n_entries * 1200;
    wait (rst === 1'b0);
    wait_cycles(4);
    verify_ports(-1);  // reset values on the ports.
    i = 0;
    while (i < n_entries)
    begin
      if (t_par[i] && i + 1 < n_entries)
      begin
        fork
          run_entry(i + 1, got_b);
          begin
            wait_cycles(HOST_LAG);
            run_entry(i, got_a);
          end
        join
        close_entry(i, got_a);
        close_entry(i + 1, got_b);
        verify_ports(i + 1);
        i = i + 2;
      end
      else
      begin
        run_entry(i, got_a);
        close_entry(i, got_a);
        verify_ports(i);
        i = i + 1;
      end
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- dv/tb_clock.sv
/*
  Testbench clock and reset.
  10 ns clock on cs, synchronous reset held for the first 10 cycles.
*/
`timescale 1ns/1ps

module tb_clock
(
  output logic cs,
  output logic rst
);

  localparam int HALF_NS    = 5;   // half of the 10 ns period.
  localparam int RST_CYCLES = 10;

  initial
  begin
    cs = 1'b0;
    forever #HALF_NS cs = ~cs;
  end

  initial
  begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge cs);
    #1 rst = 1'b0;  // released just after the edge.
  end

endmodule

//--- list.f
source/regs_pkg.sv
source/spi_frame_rx.sv
source/host_port.sv
source/reg_arbiter.sv
source/reg_bank.sv
source/spi_reg_top.sv
dv/tb_clock.sv
dv/spi_reg_tb.sv

//--- source/host_port.sv
/*
  Local host peer.
  Takes a one-cycle command strobe from on-chip logic, runs it as a
  four-phase request to the arbiter and pulses host_done with the result.
*/
`timescale 1ns/1ps

module host_port
  import regs_pkg::*;
(
  input  logic              cs,
  input  logic              rst,
  input  logic              host_valid,
  input  reg_op_t           host_op,
  input  logic [ADDR_W-1:0] host_idx,
  input  logic [DATA_W-1:0] host_wdata,
  input  logic              host_rd,
  output logic              host_busy,
  output logic              host_done,
  output logic [DATA_W-1:0] host_rdata,
  output logic              req,
  output logic              rd,
  output reg_op_t           op,
  output logic [ADDR_W-1:0] idx,
  output logic [DATA_W-1:0] wdata,
  input  logic              ack,
  input  logic [DATA_W-1:0] rdata
);

  typedef enum logic [1:0] {HP_IDLE, HP_REQ, HP_REL} hp_state_t;

  hp_state_t state;

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      state     <= HP_IDLE;
      req       <= 1'b0;
      host_busy <= 1'b0;
      host_done <= 1'b0;
    end
    else
    begin
      host_done <= 1'b0;  // single cycle pulse.
      case (state)
        HP_IDLE:
          if (host_valid)
          begin
            req       <= 1'b1;
            host_busy <= 1'b1;
            state     <= HP_REQ;
          end
        HP_REQ:
          if (ack)
          begin
            req   <= 1'b0;
            state <= HP_REL;
          end
        HP_REL:
          if (!ack)
          begin
            host_busy <= 1'b0;
            host_done <= 1'b1;  // result already in host_rdata.
            state     <= HP_IDLE;
          end
        default: state <= HP_IDLE;
      endcase
    end
  end

  // command latch and result capture.
  always_ff @(posedge cs)
  begin
    if (state == HP_IDLE && host_valid)
    begin
      op    <= host_op;
      idx   <= host_idx;
      wdata <= host_wdata;
      rd    <= host_rd;
    end
    if (state == HP_REQ && ack)
      host_rdata <= rdata;
  end

endmodule

//--- source/reg_arbiter.sv
/*
  Round-robin arbiter for the register bank.
  Grants one peer at a time, puts its request on the bank for a single
  acc_en cycle and answers with ack and read data until the peer lets go
  of req. Under contention the peer not served last wins.
*/
`timescale 1ns/1ps

module reg_arbiter
  import regs_pkg::*;
(
  input  logic              cs,
  input  logic              rst,
  input  logic              spi_req,
  input  logic              spi_rd,
  input  reg_op_t           spi_op,
  input  logic [ADDR_W-1:0] spi_idx,
  input  logic [DATA_W-1:0] spi_wdata,
  output logic              spi_ack,
  output logic [DATA_W-1:0] spi_rdata,
  input  logic              host_req,
  input  logic              host_rd,
  input  reg_op_t           host_op,
  input  logic [ADDR_W-1:0] host_idx,
  input  logic [DATA_W-1:0] host_wdata,
  output logic              host_ack,
  output logic [DATA_W-1:0] host_rdata,
  output logic              acc_en,
  output logic              acc_rd,
  output reg_op_t           acc_op,
  output logic [ADDR_W-1:0] acc_idx,
  output logic [DATA_W-1:0] acc_wdata,
  input  logic [DATA_W-1:0] acc_rdata
);

  typedef enum logic [1:0] {AR_IDLE, AR_ACCESS, AR_ACK} ar_state_t;

  ar_state_t         state;
  logic              sel_host;   // granted peer, also the one served last.
  logic              ack_q;
  logic              fresh;      // bank data arrives this cycle.
  logic [DATA_W-1:0] rdata_q;
  logic [DATA_W-1:0] rdata_out;
  logic              gnt_req;

  assign gnt_req = sel_host ? host_req : spi_req;

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      state    <= AR_IDLE;
      sel_host <= 1'b0;
      ack_q    <= 1'b0;
      fresh    <= 1'b0;
    end
    else
    begin
      fresh <= acc_en;
      case (state)
        AR_IDLE:
          if (spi_req || host_req)
          begin
            // both waiting, take the other one this time.
            sel_host <= host_req && (!spi_req || !sel_host);
            state    <= AR_ACCESS;
          end
        AR_ACCESS:
        begin
          ack_q <= 1'b1;  // bank data valid next cycle.
          state <= AR_ACK;
        end
        AR_ACK:
          if (!gnt_req)
          begin
            ack_q <= 1'b0;
            state <= AR_IDLE;
          end
        default: state <= AR_IDLE;
      endcase
    end
  end

  // hold the bank answer for the rest of the handshake.
  always_ff @(posedge cs)
  begin
    if (fresh)
      rdata_q <= acc_rdata;
  end

  assign rdata_out = fresh ? acc_rdata : rdata_q;

  // granted peer onto the bank.
  assign acc_en    = (state == AR_ACCESS);
  assign acc_rd    = sel_host ? host_rd    : spi_rd;
  assign acc_op    = sel_host ? host_op    : spi_op;
  assign acc_idx   = sel_host ? host_idx   : spi_idx;
  assign acc_wdata = sel_host ? host_wdata : spi_wdata;

  assign spi_ack    = ack_q & ~sel_host;
  assign host_ack   = ack_q & sel_host;
  assign spi_rdata  = rdata_out;  // qualified by spi_ack.
  assign host_rdata = rdata_out;

endmodule

//--- source/reg_bank.sv
/*
  Control register bank.
  Five 32-bit registers with write, set, clear and toggle updates, and a
  registered read mux that returns the fill pattern for unknown indices.
  Each register is also a port of the block.
*/
`timescale 1ns/1ps

module reg_bank
  import regs_pkg::*;
(
  input  logic              cs,
  input  logic              rst,
  input  logic              acc_en,
  input  logic              acc_rd,
  input  reg_op_t           acc_op,
  input  logic [ADDR_W-1:0] acc_idx,
  input  logic [DATA_W-1:0] acc_wdata,
  output logic [DATA_W-1:0] acc_rdata,
  output logic [DATA_W-1:0] reg_led,
  output logic [DATA_W-1:0] reg_spi_mux,
  output logic [DATA_W-1:0] reg_4094,
  output logic [DATA_W-1:0] reg_mode,
  output logic [DATA_W-1:0] reg_direct
);

  logic [DATA_W-1:0] cur_val;   // addressed register.
  logic [DATA_W-1:0] next_val;  // its updated value.
  logic              wr_en;

  // set/clear/toggle as masks, clear wins over set.
  function automatic logic [DATA_W-1:0] apply_op(
    input logic [DATA_W-1:0] cur,
    input reg_op_t           op,
    input logic [DATA_W-1:0] val
  );
    logic [DATA_W-1:0] set_m;
    logic [DATA_W-1:0] clr_m;
    logic [DATA_W-1:0] tgl_m;
    set_m = '0;
    clr_m = '0;
    tgl_m = '0;
    case (op)
      OP_WRITE:
      begin
        set_m = val;   // ones in.
        clr_m = ~val;  // zeros in.
      end
      OP_SET:    set_m = val;
      OP_CLEAR:  clr_m = val;
      OP_TOGGLE: tgl_m = val;
      default:   tgl_m = '0;
    endcase
    return ((cur | set_m) & ~clr_m) ^ tgl_m;
  endfunction

  // read mux, also the source of the update.
  always_comb
  begin
    case (acc_idx)
      IDX_LED:     cur_val = reg_led;
      IDX_SPI_MUX: cur_val = reg_spi_mux;
      IDX_4094:    cur_val = reg_4094;
      IDX_MODE:    cur_val = reg_mode;
      IDX_DIRECT:  cur_val = reg_direct;
      default:     cur_val = FILL_PATTERN;
    endcase
  end

  assign next_val = apply_op(cur_val, acc_op, acc_wdata);
  assign wr_en    = acc_en & ~acc_rd;  // rd set means read, whatever the op.

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      reg_led     <= RST_LED;
      reg_spi_mux <= '0;  // no spi device selected.
      reg_4094    <= '0;
      reg_mode    <= '0;
      reg_direct  <= '0;
    end
    else if (wr_en)
    begin
      case (acc_idx)
        IDX_LED:     reg_led     <= next_val;
        IDX_SPI_MUX: reg_spi_mux <= next_val;
        IDX_4094:    reg_4094    <= next_val;
        IDX_MODE:    reg_mode    <= next_val;
        IDX_DIRECT:  reg_direct  <= next_val;
        default:     ;  // unknown index, dropped.
      endcase
    end
  end

  // value before any update of the same cycle.
  always_ff @(posedge cs)
  begin
    if (acc_en)
      acc_rdata <= cur_val;
  end

endmodule

//--- source/regs_pkg.sv
/*
  Register map package for the SPI register block.
  Holds the field widths, the frame layout, the operation codes,
  the register indices and their reset values.
  Command byte, MSB first: bit 7 read flag, bits 6..5 operation,
  bits 4..0 register index.
*/
package regs_pkg;

  // field widths.
  localparam int ADDR_W      = 5;   // register index.
  localparam int DATA_W      = 32;  // register payload.

  // frame layout, command byte then pad byte then data.
  localparam int FRAME_BITS  = 48;
  localparam int CMD_BITS    = 8;

  // depth of the pin synchronizers.
  localparam int SYNC_STAGES = 2;

  // update operations carried in the command byte.
  typedef enum logic [1:0] {
    OP_WRITE  = 2'd0,  // replace.
    OP_SET    = 2'd1,  // or in.
    OP_CLEAR  = 2'd2,  // and out.
    OP_TOGGLE = 2'd3   // xor.
  } reg_op_t;

  // register indices.
  localparam logic [ADDR_W-1:0] IDX_LED     = 5'd7;
  localparam logic [ADDR_W-1:0] IDX_SPI_MUX = 5'd8;
  localparam logic [ADDR_W-1:0] IDX_4094    = 5'd9;
  localparam logic [ADDR_W-1:0] IDX_MODE    = 5'd12;
  localparam logic [ADDR_W-1:0] IDX_DIRECT  = 5'd14;

  // alternating pattern on the leds, handy to spot a dead board.
  localparam logic [DATA_W-1:0] RST_LED      = 32'h00aa_aaaa;

  // returned for any index not in the map.
  localparam logic [DATA_W-1:0] FILL_PATTERN = 32'h0f0f_0f0f;

endpackage

//--- source/spi_frame_rx.sv
/*
  SPI target front end.
  Samples sclk, ss_n and mosi into the cs domain, counts the bits of a
  48-bit frame and decodes the command byte. Issues a read request after
  the command byte and a write request when a full frame closes. Read
  data goes out on miso MSB first from bit 16 on.
*/
`timescale 1ns/1ps

module spi_frame_rx
  import regs_pkg::*;
(
  input  logic              cs,
  input  logic              rst,
  input  logic              sclk,
  input  logic              ss_n,
  input  logic              mosi,
  output logic              miso,
  output logic              req,
  output logic              rd,
  output reg_op_t           op,
  output logic [ADDR_W-1:0] idx,
  output logic [DATA_W-1:0] wdata,
  input  logic              ack,
  input  logic [DATA_W-1:0] rdata
);

  typedef enum logic [1:0] {HS_IDLE, HS_REQ, HS_REL} hs_state_t;

  logic [SYNC_STAGES-1:0]      sclk_q;
  logic [SYNC_STAGES-1:0]      ss_q;
  logic [SYNC_STAGES-1:0]      mosi_q;
  logic                        sclk_d;
  logic                        ss_d;
  logic                        sclk_rise;
  logic                        sclk_fall;
  logic                        ss_high;
  logic                        ss_rise;
  logic [$clog2(FRAME_BITS):0] bit_cnt;   // saturates, so long frames never alias 48.
  logic [FRAME_BITS-1:0]       in_sr;
  logic [DATA_W-1:0]           out_sr;
  logic                        cmd_pulse;  // command byte complete in in_sr.
  logic                        cmd_new;    // command fields latched.
  logic                        cmd_rd;
  reg_op_t                     cmd_op;
  logic [ADDR_W-1:0]           cmd_idx;
  logic                        start_rd;
  logic                        start_wr;
  hs_state_t                   hs_state;

  // pin synchronizers, chip select idles high.
  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      sclk_q <= '0;
      ss_q   <= '1;
      mosi_q <= '0;
      sclk_d <= 1'b0;
      ss_d   <= 1'b1;
    end
    else
    begin
      sclk_q <= {sclk_q[SYNC_STAGES-2:0], sclk};
      ss_q   <= {ss_q[SYNC_STAGES-2:0], ss_n};
      mosi_q <= {mosi_q[SYNC_STAGES-2:0], mosi};
      sclk_d <= sclk_q[SYNC_STAGES-1];
      ss_d   <= ss_q[SYNC_STAGES-1];
    end
  end

  assign sclk_rise = sclk_q[SYNC_STAGES-1] & ~sclk_d;
  assign sclk_fall = ~sclk_q[SYNC_STAGES-1] & sclk_d;
  assign ss_high   = ss_q[SYNC_STAGES-1];
  assign ss_rise   = ss_high & ~ss_d;  // end of frame.

  // bit counter and shift registers, held clear while deselected.
  always_ff @(posedge cs)
  begin
    if (rst || ss_high)
    begin
      bit_cnt   <= '0;
      in_sr     <= '0;
      out_sr    <= '0;
      miso      <= 1'b0;
      cmd_pulse <= 1'b0;
    end
    else
    begin
      cmd_pulse <= 1'b0;
      if (sclk_rise)
      begin
        in_sr <= {in_sr[FRAME_BITS-2:0], mosi_q[SYNC_STAGES-1]};  // msb first.
        if (bit_cnt != '1)
          bit_cnt <= bit_cnt + 1'b1;
        cmd_pulse <= (bit_cnt == CMD_BITS - 1);  // 8th bit arriving.
      end
      // pad byte gives time to fetch the data.
      if (hs_state == HS_REQ && ack && rd)
        out_sr <= rdata;
      else if (sclk_fall && bit_cnt >= 2 * CMD_BITS)
      begin
        miso   <= out_sr[DATA_W-1];
        out_sr <= {out_sr[DATA_W-2:0], 1'b0};  // zero fill.
      end
    end
  end

  // command byte fields, payload only.
  always_ff @(posedge cs)
  begin
    if (cmd_pulse)
    begin
      cmd_op  <= reg_op_t'(in_sr[CMD_BITS-2 -: 2]);
      cmd_idx <= in_sr[ADDR_W-1:0];
    end
  end

  assign start_rd = cmd_new & cmd_rd;
  // bit_cnt still holds the old count on the ss rise cycle.
  assign start_wr = ss_rise && (bit_cnt == FRAME_BITS) && !cmd_rd;

  // four-phase handshake toward the arbiter.
  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      hs_state <= HS_IDLE;
      req      <= 1'b0;
      rd       <= 1'b0;
      cmd_rd   <= 1'b0;
      cmd_new  <= 1'b0;
    end
    else
    begin
      cmd_new <= cmd_pulse;
      if (cmd_pulse)
        cmd_rd <= in_sr[CMD_BITS-1];  // 1 means read.
      case (hs_state)
        HS_IDLE:
          if (start_rd || start_wr)
          begin
            req      <= 1'b1;
            rd       <= start_rd;
            hs_state <= HS_REQ;
          end
        HS_REQ:
          if (ack)
          begin
            req      <= 1'b0;  // data taken.
            hs_state <= HS_REL;
          end
        HS_REL:
          if (!ack)
            hs_state <= HS_IDLE;
        default: hs_state <= HS_IDLE;
      endcase
    end
  end

  // request payload, stable while req is high.
  always_ff @(posedge cs)
  begin
    if (hs_state == HS_IDLE && (start_rd || start_wr))
    begin
      op    <= cmd_op;
      idx   <= cmd_idx;
      wdata <= in_sr[DATA_W-1:0];  // low 32 bits of the frame.
    end
  end

endmodule

//--- source/spi_reg_top.sv
/*
  SPI register block top.
  The SPI front end and the local host port share the register bank
  through a round-robin arbiter. Register ports come straight from the bank.
*/
`timescale 1ns/1ps

module spi_reg_top
  import regs_pkg::*;
(
  input  logic              cs,
  input  logic              rst,
  input  logic              sclk,
  input  logic              ss_n,
  input  logic              mosi,
  output logic              miso,
  input  logic              host_valid,
  input  reg_op_t           host_op,
  input  logic [ADDR_W-1:0] host_idx,
  input  logic [DATA_W-1:0] host_wdata,
  input  logic              host_rd,
  output logic              host_busy,
  output logic              host_done,
  output logic [DATA_W-1:0] host_rdata,
  output logic [DATA_W-1:0] reg_led,
  output logic [DATA_W-1:0] reg_spi_mux,
  output logic [DATA_W-1:0] reg_4094,
  output logic [DATA_W-1:0] reg_mode,
  output logic [DATA_W-1:0] reg_direct
);

  // spi peer channel.
  logic              spi_req;
  logic              spi_rd;
  reg_op_t           spi_op;
  logic [ADDR_W-1:0] spi_idx;
  logic [DATA_W-1:0] spi_wdata;
  logic              spi_ack;
  logic [DATA_W-1:0] spi_rdata;

  // host peer channel.
  logic              hp_req;
  logic              hp_rd;
  reg_op_t           hp_op;
  logic [ADDR_W-1:0] hp_idx;
  logic [DATA_W-1:0] hp_wdata;
  logic              hp_ack;
  logic [DATA_W-1:0] hp_rdata;

  // bank access.
  logic              acc_en;
  logic              acc_rd;
  reg_op_t           acc_op;
  logic [ADDR_W-1:0] acc_idx;
  logic [DATA_W-1:0] acc_wdata;
  logic [DATA_W-1:0] acc_rdata;

  spi_frame_rx spi_rx0 (
    .cs    (cs),
    .rst   (rst),
    .sclk  (sclk),
    .ss_n  (ss_n),
    .mosi  (mosi),
    .miso  (miso),
    .req   (spi_req),
    .rd    (spi_rd),
    .op    (spi_op),
    .idx   (spi_idx),
    .wdata (spi_wdata),
    .ack   (spi_ack),
    .rdata (spi_rdata)
  );

  host_port host0 (
    .cs         (cs),
    .rst        (rst),
    .host_valid (host_valid),
    .host_op    (host_op),
    .host_idx   (host_idx),
    .host_wdata (host_wdata),
    .host_rd    (host_rd),
    .host_busy  (host_busy),
    .host_done  (host_done),
    .host_rdata (host_rdata),
    .req        (hp_req),
    .rd         (hp_rd),
    .op         (hp_op),
    .idx        (hp_idx),
    .wdata      (hp_wdata),
    .ack        (hp_ack),
    .rdata      (hp_rdata)
  );

  reg_arbiter arb0 (
    .cs         (cs),
    .rst        (rst),
    .spi_req    (spi_req),
    .spi_rd     (spi_rd),
    .spi_op     (spi_op),
    .spi_idx    (spi_idx),
    .spi_wdata  (spi_wdata),
    .spi_ack    (spi_ack),
    .spi_rdata  (spi_rdata),
    .host_req   (hp_req),
    .host_rd    (hp_rd),
    .host_op    (hp_op),
    .host_idx   (hp_idx),
    .host_wdata (hp_wdata),
    .host_ack   (hp_ack),
    .host_rdata (hp_rdata),
    .acc_en     (acc_en),
    .acc_rd     (acc_rd),
    .acc_op     (acc_op),
    .acc_idx    (acc_idx),
    .acc_wdata  (acc_wdata),
    .acc_rdata  (acc_rdata)
  );

  reg_bank bank0 (
    .cs          (cs),
    .rst         (rst),
    .acc_en      (acc_en),
    .acc_rd      (acc_rd),
    .acc_op      (acc_op),
    .acc_idx     (acc_idx),
    .acc_wdata   (acc_wdata),
    .acc_rdata   (acc_rdata),
    .reg_led     (reg_led),
    .reg_spi_mux (reg_spi_mux),
    .reg_4094    (reg_4094),
    .reg_mode    (reg_mode),
    .reg_direct  (reg_direct)
  );

endmodule
